//--- verilog/control_macros.svh
`ifndef CONTROL_MACROS_SVH
`define CONTROL_MACROS_SVH

// Word and field widths
`define INSTR_W     32
`define OPCODE_W    6
`define FUNCT_W     6
`define RT_W        5
`define ALU_OP_W    5
`define BYTE_EN_W   4

// Field positions inside the instruction word
`define OPCODE_LSB  26
`define RT_LSB      16
`define FUNCT_LSB   0

// Memory lane strobes
`define BYTE_EN_WORD 4'b1111
`define BYTE_EN_HALF 4'b0011
`define BYTE_EN_BYTE 4'b0001

`endif

//--- verilog/controlPkg.sv
`include "control_macros.svh"

package controlPkg;

  typedef logic [`INSTR_W-1:0] instrT;

  // Primary opcodes that the control unit executes
  typedef enum logic [`OPCODE_W-1:0] {
    OP_RTYPE  = 6'b000000,
    OP_REGIMM = 6'b000001,
    OP_J      = 6'b000010,
    OP_BEQ    = 6'b000100,
    OP_BNE    = 6'b000101,
    OP_BLEZ   = 6'b000110,
    OP_BGTZ   = 6'b000111,
    OP_ADDIU  = 6'b001001,
    OP_SLTI   = 6'b001010,
    OP_SLTIU  = 6'b001011,
    OP_ANDI   = 6'b001100,
    OP_ORI    = 6'b001101,
    OP_XORI   = 6'b001110,
    OP_LUI    = 6'b001111,
    OP_LB     = 6'b100000,
    OP_LH     = 6'b100001,
    OP_LW     = 6'b100011,
    OP_LBU    = 6'b100100,
    OP_LHU    = 6'b100101,
    OP_SW     = 6'b101011
  } opcodeT;

  // R-type function field
  typedef enum logic [`FUNCT_W-1:0] {
    FN_JR   = 6'b001000,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } functT;

  // REGIMM rt field
  typedef enum logic [`RT_W-1:0] {
    BR_BLTZ = 5'b00000,
    BR_BGEZ = 5'b00001
  } branchCodeT;

  typedef enum logic [2:0] {
    FETCH  = 3'b000,
    DECODE = 3'b001,
    EXEC_1 = 3'b010,
    EXEC_2 = 3'b011,
    EXEC_3 = 3'b100,
    HALTED = 3'b101,
    STALL  = 3'b110
  } cpuStateT;

  // Operation codes understood by the ALU
  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_AND           = 5'b00000,
    ALU_OR            = 5'b00001,
    ALU_ADD           = 5'b00010,
    ALU_XOR           = 5'b00011,
    ALU_SLT           = 5'b00111,
    ALU_SLTU          = 5'b01001,
    ALU_EQ            = 5'b01010,
    ALU_PASS_B        = 5'b01011,
    ALU_SIGN          = 5'b01100,
    ALU_BRANCH_TARGET = 5'b01101,
    ALU_PASS_A        = 5'b01110,
    ALU_FUNCT         = 5'b01111,
    ALU_LEZ           = 5'b10000,
    ALU_JUMP_TARGET   = 5'b10001,
    ALU_LUI           = 5'b10100
  } aluOpT;

  typedef enum logic [1:0] {
    SRC_B_REG    = 2'b00,
    SRC_B_FOUR   = 2'b01,
    SRC_B_IMM    = 2'b10,
    SRC_B_OFFSET = 2'b11
  } aluSrcBT;

  typedef enum logic [3:0] {
    CLASS_ALU_REG,
    CLASS_ALU_IMM,
    CLASS_LUI,
    CLASS_LOAD,
    CLASS_STORE,
    CLASS_BRANCH,
    CLASS_JUMP,
    CLASS_JUMP_REG,
    CLASS_NONE
  } instrClassT;

  typedef enum logic [2:0] {
    LOAD_WORD,
    LOAD_HALF,
    LOAD_HALF_U,
    LOAD_BYTE,
    LOAD_BYTE_U
  } loadKindT;

  typedef enum logic [2:0] {
    COND_EQ,
    COND_NE,
    COND_GTZ,
    COND_LEZ,
    COND_LTZ,
    COND_GEZ,
    COND_ALWAYS
  } branchCondT;

  typedef logic [`BYTE_EN_W-1:0] byteEnT;

  // Sign extension of loaded data
  typedef enum logic [1:0] {
    EXT_NONE = 2'b00,
    EXT_BYTE = 2'b10,
    EXT_HALF = 2'b11
  } memExtT;

endpackage

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`include "control_macros.svh"

module instrDecoder (
  input  controlPkg::instrT      instr,
  output controlPkg::instrClassT instrClass,
  output controlPkg::aluOpT      aluOp,
  output controlPkg::loadKindT   loadKind,
  output controlPkg::branchCondT branchCond,
  output logic                   zeroExtend
);
  import controlPkg::*;

  opcodeT     opcode;
  functT      funct;
  branchCodeT branchCode;

  assign opcode     = opcodeT'(instr[`OPCODE_LSB +: `OPCODE_W]);
  assign funct      = functT'(instr[`FUNCT_LSB +: `FUNCT_W]);
  assign branchCode = branchCodeT'(instr[`RT_LSB +: `RT_W]);

  always_comb begin
    // Anything not matched below retires after EXEC_1 with no writes
    instrClass = CLASS_NONE;
    aluOp      = ALU_ADD;
    loadKind   = LOAD_WORD;
    branchCond = COND_EQ;
    zeroExtend = 1'b0;

    case (opcode)
      OP_RTYPE: begin
        if (funct inside {FN_ADDU, FN_AND, FN_OR}) begin
          instrClass = CLASS_ALU_REG;
          aluOp      = ALU_FUNCT;
        end else if (funct == FN_JR) begin
          instrClass = CLASS_JUMP_REG;
          aluOp      = ALU_PASS_A;
          branchCond = COND_ALWAYS;
        end
      end
      OP_REGIMM: begin
        if (branchCode inside {BR_BLTZ, BR_BGEZ}) begin
          instrClass = CLASS_BRANCH;
          aluOp      = ALU_SIGN;
          branchCond = (branchCode == BR_BLTZ) ? COND_LTZ : COND_GEZ;
        end
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
        instrClass = CLASS_ALU_IMM;
        zeroExtend = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
        case (opcode)
          OP_SLTI:  aluOp = ALU_SLT;
          OP_SLTIU: aluOp = ALU_SLTU;
          OP_ANDI:  aluOp = ALU_AND;
          OP_ORI:   aluOp = ALU_OR;
          OP_XORI:  aluOp = ALU_XOR;
          default:  aluOp = ALU_ADD;
        endcase
      end
      OP_LUI: begin
        instrClass = CLASS_LUI;
        aluOp      = ALU_LUI;
      end
      OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: begin
        instrClass = CLASS_LOAD;
        case (opcode)
          OP_LH:   loadKind = LOAD_HALF;
          OP_LHU:  loadKind = LOAD_HALF_U;
          OP_LB:   loadKind = LOAD_BYTE;
          OP_LBU:  loadKind = LOAD_BYTE_U;
          default: loadKind = LOAD_WORD;
        endcase
      end
      OP_SW: begin
        instrClass = CLASS_STORE;
      end
      OP_BEQ, OP_BNE: begin
        instrClass = CLASS_BRANCH;
        aluOp      = ALU_EQ;
        branchCond = (opcode == OP_BEQ) ? COND_EQ : COND_NE;
      end
      OP_BGTZ, OP_BLEZ: begin
        instrClass = CLASS_BRANCH;
        aluOp      = ALU_LEZ;
        branchCond = (opcode == OP_BGTZ) ? COND_GTZ : COND_LEZ;
      end
      OP_J: begin
        instrClass = CLASS_JUMP;
        aluOp      = ALU_JUMP_TARGET;
        branchCond = COND_ALWAYS;
        zeroExtend = 1'b1;
      end
      default: instrClass = CLASS_NONE;
    endcase
  end

endmodule

//--- verilog/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 start,
  input  logic                 pcIsZero,
  input  logic                 waitRequest,
  input  logic                 stall,
  input  logic                 moreSteps,
  output controlPkg::cpuStateT state,
  output logic                 retire,
  output logic                 active
);
  import controlPkg::*;

  cpuStateT nextState;

  always_comb begin
    nextState = state;
    // A halt request overrides every other transition
    if (pcIsZero && state != HALTED) begin
      nextState = HALTED;
    end else begin
      case (state)
        HALTED: nextState = start ? FETCH : HALTED;
        FETCH, STALL: nextState = waitRequest ? STALL : DECODE;
        DECODE: nextState = EXEC_1;
        EXEC_1: begin
          if (!stall) begin
            nextState = moreSteps ? EXEC_2 : FETCH;
          end
        end
        EXEC_2: begin
          if (!waitRequest) begin
            nextState = moreSteps ? EXEC_3 : FETCH;
          end
        end
        EXEC_3: nextState = FETCH;
        default: nextState = HALTED;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= HALTED;
    end else begin
      state <= nextState;
    end
  end

  // Last execute step of the instruction
  assign retire = (state inside {EXEC_1, EXEC_2, EXEC_3}) && (nextState == FETCH);
  assign active = (state != HALTED);

  haltExit: assert property (@(posedge clk) disable iff (!rstN)
    state == HALTED |=> state inside {HALTED, FETCH});

endmodule

//--- verilog/datapathSelect.sv
`timescale 1ns/1ps

module datapathSelect (
  input  controlPkg::cpuStateT   state,
  input  controlPkg::instrClassT instrClass,
  input  controlPkg::aluOpT      aluOp,
  input  logic                   zeroExtend,
  output logic                   moreSteps,
  output logic                   irWrite,
  output logic                   irSel,
  output logic                   pcWrite,
  output logic                   aluSrcA,
  output controlPkg::aluSrcBT    aluSrcB,
  output controlPkg::aluOpT      aluControl,
  output logic                   aluSel,
  output logic                   extSel,
  output logic                   regWrite,
  output logic                   regDst,
  output logic                   memToReg,
  output logic                   isJump
);
  import controlPkg::*;

  logic writesAlu;
  logic accessesMem;
  logic regOperand;

  assign writesAlu   = instrClass inside {CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LUI};
  assign accessesMem = instrClass inside {CLASS_LOAD, CLASS_STORE};
  // Second operand comes from the register file
  assign regOperand  = instrClass inside {CLASS_ALU_REG, CLASS_BRANCH, CLASS_JUMP_REG};

  always_comb begin
    moreSteps  = 1'b0;
    irWrite    = 1'b0;
    irSel      = (state != DECODE);
    pcWrite    = 1'b0;
    aluSrcA    = 1'b0;
    aluSrcB    = SRC_B_REG;
    aluControl = ALU_ADD;
    aluSel     = 1'b0;
    extSel     = 1'b0;
    regWrite   = 1'b0;
    regDst     = 1'b0;
    memToReg   = 1'b0;
    isJump     = 1'b0;

    case (state)
      FETCH: begin
        // PC + 4
        pcWrite = 1'b1;
        aluSrcB = SRC_B_FOUR;
      end
      DECODE: begin
        irWrite = 1'b1;
        aluSrcB = SRC_B_OFFSET;
        if (instrClass == CLASS_JUMP) begin
          aluControl = ALU_PASS_B;
          extSel     = 1'b1;
        end else begin
          aluControl = ALU_BRANCH_TARGET;
        end
      end
      EXEC_1: begin
        aluSrcA    = 1'b1;
        aluSrcB    = regOperand ? SRC_B_REG : SRC_B_IMM;
        aluControl = aluOp;
        extSel     = zeroExtend;
        aluSel     = (instrClass == CLASS_BRANCH);
        isJump     = (instrClass == CLASS_JUMP);
        moreSteps  = writesAlu || accessesMem;
      end
      EXEC_2: begin
        aluSel    = 1'b1;
        moreSteps = (instrClass == CLASS_LOAD);
        // Result writeback from the ALU register
        regWrite  = writesAlu;
        memToReg  = writesAlu;
        regDst    = (instrClass == CLASS_ALU_REG);
      end
      EXEC_3: regWrite = (instrClass == CLASS_LOAD);
      default: moreSteps = 1'b0;
    endcase

    noEarlyWrite: assert (!(regWrite && state inside {FETCH, DECODE, STALL}))
      else $error("regWrite raised in state %s", state.name());
  end

endmodule

//--- verilog/memAccessControl.sv
`timescale 1ns/1ps
`include "control_macros.svh"

module memAccessControl (
  input  controlPkg::cpuStateT   state,
  input  controlPkg::instrClassT instrClass,
  input  controlPkg::loadKindT   loadKind,
  output logic                   iorD,
  output logic                   memRead,
  output logic                   memWrite,
  output controlPkg::byteEnT     byteEnable,
  output controlPkg::memExtT     memExt
);
  import controlPkg::*;

  logic dataPhase;
  logic isLoad;

  assign isLoad    = (instrClass == CLASS_LOAD);
  // Data access and writeback steps of a load
  assign dataPhase = isLoad && (state inside {EXEC_2, EXEC_3});

  always_comb begin
    iorD     = (state == EXEC_2) && (isLoad || instrClass == CLASS_STORE);
    memRead  = (state inside {FETCH, STALL}) || (state == EXEC_2 && isLoad);
    memWrite = (state == EXEC_2) && (instrClass == CLASS_STORE);

    byteEnable = `BYTE_EN_WORD;
    memExt     = EXT_NONE;
    if (dataPhase) begin
      case (loadKind)
        LOAD_HALF: begin
          byteEnable = `BYTE_EN_HALF;
          memExt     = EXT_HALF;
        end
        LOAD_HALF_U: byteEnable = `BYTE_EN_HALF;
        LOAD_BYTE: begin
          byteEnable = `BYTE_EN_BYTE;
          memExt     = EXT_BYTE;
        end
        LOAD_BYTE_U: byteEnable = `BYTE_EN_BYTE;
        default: byteEnable = `BYTE_EN_WORD;
      endcase
    end

    oneStrobe: assert (!(memRead && memWrite))
      else $error("memRead and memWrite both high in state %s", state.name());
  end

endmodule

//--- verilog/branchResolver.sv
`timescale 1ns/1ps

module branchResolver (
  input  logic                   clk,
  input  logic                   rstN,
  input  controlPkg::cpuStateT   state,
  input  logic                   retire,
  input  controlPkg::instrClassT instrClass,
  input  controlPkg::branchCondT branchCond,
  input  logic                   outLsb,
  input  logic                   lessThan,
  output logic                   branchDelay,
  output logic                   pcSrc
);
  import controlPkg::*;

  logic taken;
  logic redirects;

  assign redirects = instrClass inside {CLASS_BRANCH, CLASS_JUMP, CLASS_JUMP_REG};

  // ALU_LEZ raises the flag when A <= 0, so GTZ takes on a low flag
  always_comb begin
    case (branchCond)
      COND_EQ:  taken = outLsb;
      COND_NE:  taken = !outLsb;
      COND_GTZ: taken = !outLsb;
      COND_LEZ: taken = outLsb;
      COND_LTZ: taken = lessThan;
      COND_GEZ: taken = !lessThan;
      default:  taken = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      branchDelay <= 1'b0;
    end else if (retire) begin
      branchDelay <= redirects && taken;
    end
  end

  // Redirect is consumed by the fetch that follows the branch
  assign pcSrc = (state == FETCH) && branchDelay;

  redirectInFetch: assert property (@(posedge clk) disable iff (!rstN)
    pcSrc |-> state == FETCH);

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  logic                 clk,
  input  logic                 rstN,
  input  controlPkg::instrT    instr,
  input  logic                 start,
  input  logic                 pcIsZero,
  input  logic                 waitRequest,
  input  logic                 stall,
  input  logic                 outLsb,
  input  logic                 lessThan,
  output controlPkg::cpuStateT state,
  output logic                 active,
  output logic                 irWrite,
  output logic                 irSel,
  output logic                 pcWrite,
  output logic                 aluSrcA,
  output controlPkg::aluSrcBT  aluSrcB,
  output controlPkg::aluOpT    aluControl,
  output logic                 aluSel,
  output logic                 extSel,
  output logic                 regWrite,
  output logic                 regDst,
  output logic                 memToReg,
  output logic                 isJump,
  output logic                 iorD,
  output logic                 memRead,
  output logic                 memWrite,
  output controlPkg::byteEnT   byteEnable,
  output controlPkg::memExtT   memExt,
  output logic                 branchDelay,
  output logic                 pcSrc
);
  import controlPkg::*;

  instrClassT instrClass;
  aluOpT      aluOp;
  loadKindT   loadKind;
  branchCondT branchCond;
  logic       zeroExtend;
  logic       moreSteps;
  logic       retire;

  instrDecoder uInstrDecoder (
    .instr      (instr),
    .instrClass (instrClass),
    .aluOp      (aluOp),
    .loadKind   (loadKind),
    .branchCond (branchCond),
    .zeroExtend (zeroExtend)
  );

  cycleSequencer uCycleSequencer (
    .clk         (clk),
    .rstN        (rstN),
    .start       (start),
    .pcIsZero    (pcIsZero),
    .waitRequest (waitRequest),
    .stall       (stall),
    .moreSteps   (moreSteps),
    .state       (state),
    .retire      (retire),
    .active      (active)
  );

  datapathSelect uDatapathSelect (
    .state      (state),
    .instrClass (instrClass),
    .aluOp      (aluOp),
    .zeroExtend (zeroExtend),
    .moreSteps  (moreSteps),
    .irWrite    (irWrite),
    .irSel      (irSel),
    .pcWrite    (pcWrite),
    .aluSrcA    (aluSrcA),
    .aluSrcB    (aluSrcB),
    .aluControl (aluControl),
    .aluSel     (aluSel),
    .extSel     (extSel),
    .regWrite   (regWrite),
    .regDst     (regDst),
    .memToReg   (memToReg),
    .isJump     (isJump)
  );

  memAccessControl uMemAccessControl (
    .state      (state),
    .instrClass (instrClass),
    .loadKind   (loadKind),
    .iorD       (iorD),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .byteEnable (byteEnable),
    .memExt     (memExt)
  );

  branchResolver uBranchResolver (
    .clk         (clk),
    .rstN        (rstN),
    .state       (state),
    .retire      (retire),
    .instrClass  (instrClass),
    .branchCond  (branchCond),
    .outLsb      (outLsb),
    .lessThan    (lessThan),
    .branchDelay (branchDelay),
    .pcSrc       (pcSrc)
  );

endmodule

//--- verif/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held low for the first two rising edges
  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

//--- verif/tbControlUnit.sv
`timescale 1ns/1ps
`include "control_macros.svh"

module tbControlUnit;
  import controlPkg::*;

  localparam int NumInstr = 400;
  // Five steps per instruction at most, four times over for waits and halts
  localparam int CycleLimit = NumInstr * 5 * 4;

  localparam opcodeT keptOps [20] = '{
    OP_RTYPE, OP_REGIMM, OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
    OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SW
  };
  localparam functT rtypeFuncts [4] = '{FN_ADDU, FN_AND, FN_OR, FN_JR};

  logic clk;
  logic rstN;
  instrT instr;
  logic start, pcIsZero, waitRequest, stall, outLsb, lessThan;

  cpuStateT state;
  aluSrcBT aluSrcB;
  aluOpT aluControl;
  byteEnT byteEnable;
  memExtT memExt;
  logic active, irWrite, irSel, pcWrite, aluSrcA, aluSel, extSel;
  logic regWrite, regDst, memToReg, isJump;
  logic iorD, memRead, memWrite, branchDelay, pcSrc;

  logic [31:0] seed;
  cpuStateT modelState;
  logic modelDelay;
  int retired;
  int cycles;
  int errors;
  int checks;

  tbClock clockGen (
    .clk  (clk),
    .rstN (rstN)
  );

  controlUnit u_dut (.*);

  function automatic logic [31:0] lcgNext();
    seed = seed * 32'd1664525 + 32'd1013904223;
    // Low LCG bits repeat quickly, so the upper half is returned low
    return {seed[15:0], seed[31:16]};
  endfunction

  function automatic logic [5:0] opcodeOf(instrT w);
    return w[`OPCODE_LSB +: `OPCODE_W];
  endfunction

  function automatic instrT randomInstr();
    instrT word;
    logic [4:0] pick;
    word = lcgNext();
    pick = 5'(lcgNext() % 32'd22);
    if (pick < 5'd20) begin
      word[`OPCODE_LSB +: `OPCODE_W] = keptOps[pick];
    end else begin
      // Opcodes 0x30 to 0x3f are all unknown to the unit
      word[`OPCODE_LSB +: `OPCODE_W] = {2'b11, word[29:26]};
    end
    if (opcodeOf(word) == OP_RTYPE) begin
      word[`FUNCT_LSB +: `FUNCT_W] = rtypeFuncts[2'(lcgNext())];
    end
    if (opcodeOf(word) == OP_REGIMM) begin
      if ((lcgNext() % 32'd2) == 32'd0) begin
        word[`RT_LSB +: `RT_W] = BR_BLTZ;
      end else begin
        word[`RT_LSB +: `RT_W] = BR_BGEZ;
      end
    end
    return word;
  endfunction

  function automatic instrClassT classOf(instrT w);
    case (opcodeOf(w))
      OP_RTYPE: begin
        if (w[`FUNCT_LSB +: `FUNCT_W] == FN_JR) return CLASS_JUMP_REG;
        if (w[`FUNCT_LSB +: `FUNCT_W] inside {FN_ADDU, FN_AND, FN_OR}) return CLASS_ALU_REG;
        return CLASS_NONE;
      end
      OP_REGIMM: begin
        if (w[`RT_LSB +: `RT_W] inside {BR_BLTZ, BR_BGEZ}) return CLASS_BRANCH;
        return CLASS_NONE;
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: return CLASS_ALU_IMM;
      OP_LUI: return CLASS_LUI;
      OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: return CLASS_LOAD;
      OP_SW: return CLASS_STORE;
      OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: return CLASS_BRANCH;
      OP_J: return CLASS_JUMP;
      default: return CLASS_NONE;
    endcase
  endfunction

  function automatic cpuStateT lastStep(instrClassT cls);
    case (cls)
      CLASS_LOAD: return EXEC_3;
      CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LUI, CLASS_STORE: return EXEC_2;
      default: return EXEC_1;
    endcase
  endfunction

  function automatic aluOpT aluOpOf(instrT w);
    case (opcodeOf(w))
      OP_RTYPE: begin
        if (w[`FUNCT_LSB +: `FUNCT_W] == FN_JR) return ALU_PASS_A;
        return ALU_FUNCT;
      end
      OP_REGIMM: return ALU_SIGN;
      OP_SLTI: return ALU_SLT;
      OP_SLTIU: return ALU_SLTU;
      OP_ANDI: return ALU_AND;
      OP_ORI: return ALU_OR;
      OP_XORI: return ALU_XOR;
      OP_LUI: return ALU_LUI;
      OP_BEQ, OP_BNE: return ALU_EQ;
      OP_BGTZ, OP_BLEZ: return ALU_LEZ;
      OP_J: return ALU_JUMP_TARGET;
      default: return ALU_ADD;
    endcase
  endfunction

  // Redirect decision at retire, low for every class that never redirects
  function automatic logic takenFor(instrT w, logic lsb, logic lt);
    if (classOf(w) == CLASS_NONE) return 1'b0;
    case (opcodeOf(w))
      OP_BEQ, OP_BLEZ: return lsb;
      OP_BNE, OP_BGTZ: return !lsb;
      OP_REGIMM: return (w[`RT_LSB +: `RT_W] == BR_BLTZ) ? lt : !lt;
      OP_J: return 1'b1;
      OP_RTYPE: return (w[`FUNCT_LSB +: `FUNCT_W] == FN_JR);
      default: return 1'b0;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic finishRun(input logic timedOut);
    $display("Errors: %0d, checks: %0d, instructions retired: %0d", errors, checks, retired);
    if (errors == 0 && !timedOut) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // Reference state machine and stimulus, both stepped on the rising edge
  initial begin : driveStimulus
    instrClassT cls;
    cpuStateT nextModel;
    seed = 32'he82d;
    instr = '0;
    start = 1'b0;
    pcIsZero = 1'b0;
    waitRequest = 1'b0;
    stall = 1'b0;
    outLsb = 1'b0;
    lessThan = 1'b0;
    modelState = HALTED;
    modelDelay = 1'b0;
    forever begin
      @(posedge clk);
      cls = classOf(instr);
      nextModel = modelState;
      if (!rstN) begin
        nextModel = HALTED;
      end else if (pcIsZero && modelState != HALTED) begin
        nextModel = HALTED;
      end else begin
        case (modelState)
          HALTED: if (start) nextModel = FETCH;
          FETCH, STALL: begin
            if (waitRequest) nextModel = STALL;
            else nextModel = DECODE;
          end
          DECODE: nextModel = EXEC_1;
          EXEC_1: begin
            if (!stall && lastStep(cls) == EXEC_1) nextModel = FETCH;
            else if (!stall) nextModel = EXEC_2;
          end
          EXEC_2: begin
            if (!waitRequest && lastStep(cls) == EXEC_2) nextModel = FETCH;
            else if (!waitRequest) nextModel = EXEC_3;
          end
          EXEC_3: nextModel = FETCH;
          default: nextModel = HALTED;
        endcase
      end
      if (rstN && modelState inside {EXEC_1, EXEC_2, EXEC_3} && nextModel == FETCH) begin
        modelDelay = takenFor(instr, outLsb, lessThan);
        retired++;
      end
      modelState = nextModel;

      // New instruction word for every fetch
      if (nextModel == FETCH) instr <= randomInstr();
      start <= (nextModel == HALTED) && ((lcgNext() % 32'd2) == 32'd1);
      pcIsZero <= (lcgNext() % 32'd64) == 32'd0;
      waitRequest <= (lcgNext() % 32'd4) == 32'd0;
      stall <= (lcgNext() % 32'd4) == 32'd0;
      outLsb <= (lcgNext() % 32'd2) == 32'd1;
      lessThan <= (lcgNext() % 32'd2) == 32'd1;
    end
  end

  // Outputs compared on the falling edge, where they are settled
  initial begin : checkOutputs
    instrClassT cls;
    logic finalWrite;
    logic dataStep;
    logic checkAlu;
    logic expExtSel;
    byteEnT expLanes;
    memExtT expExt;
    aluOpT expAlu;
    aluSrcBT expSrcB;
    while (cycles < CycleLimit && retired < NumInstr) begin
      @(negedge clk);
      cycles++;
      cls = classOf(instr);
      finalWrite = (modelState == lastStep(cls)) &&
                   (cls inside {CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LUI, CLASS_LOAD});
      dataStep = (cls == CLASS_LOAD) && (modelState inside {EXEC_2, EXEC_3});
      expLanes = `BYTE_EN_WORD;
      expExt = EXT_NONE;
      if (dataStep) begin
        case (opcodeOf(instr))
          OP_LH: begin
            expLanes = `BYTE_EN_HALF;
            expExt = EXT_HALF;
          end
          OP_LHU: expLanes = `BYTE_EN_HALF;
          OP_LB: begin
            expLanes = `BYTE_EN_BYTE;
            expExt = EXT_BYTE;
          end
          OP_LBU: expLanes = `BYTE_EN_BYTE;
          default: expLanes = `BYTE_EN_WORD;
        endcase
      end
      checkAlu = 1'b1;
      expAlu = ALU_ADD;
      expSrcB = SRC_B_FOUR;
      expExtSel = 1'b0;
      case (modelState)
        FETCH: expSrcB = SRC_B_FOUR;
        DECODE: begin
          expSrcB = SRC_B_OFFSET;
          expExtSel = (cls == CLASS_JUMP);
          if (cls == CLASS_JUMP) expAlu = ALU_PASS_B;
          else expAlu = ALU_BRANCH_TARGET;
        end
        EXEC_1: begin
          expAlu = aluOpOf(instr);
          // Logic immediates and the jump index are zero extended
          expExtSel = opcodeOf(instr) inside {OP_ANDI, OP_ORI, OP_XORI, OP_J};
          if (cls inside {CLASS_ALU_REG, CLASS_BRANCH, CLASS_JUMP_REG}) expSrcB = SRC_B_REG;
          else expSrcB = SRC_B_IMM;
          checkAlu = (cls != CLASS_NONE);
        end
        default: checkAlu = 1'b0;
      endcase

      checkValue("state", 32'(modelState), 32'(state));
      checkValue("active", 32'(modelState != HALTED), 32'(active));
      checkValue("irWrite", 32'(modelState == DECODE), 32'(irWrite));
      checkValue("irSel", 32'(modelState != DECODE), 32'(irSel));
      checkValue("pcWrite", 32'(modelState == FETCH), 32'(pcWrite));
      checkValue("aluSrcA", 32'(modelState == EXEC_1), 32'(aluSrcA));
      checkValue("aluSel", 32'(modelState == EXEC_2 ||
                               (modelState == EXEC_1 && cls == CLASS_BRANCH)), 32'(aluSel));
      checkValue("extSel", 32'(expExtSel), 32'(extSel));
      checkValue("regWrite", 32'(finalWrite), 32'(regWrite));
      checkValue("memToReg", 32'(finalWrite && cls != CLASS_LOAD), 32'(memToReg));
      checkValue("regDst", 32'(finalWrite && cls == CLASS_ALU_REG), 32'(regDst));
      checkValue("isJump", 32'(modelState == EXEC_1 && cls == CLASS_JUMP), 32'(isJump));
      checkValue("memRead", 32'(modelState inside {FETCH, STALL} ||
                                (modelState == EXEC_2 && cls == CLASS_LOAD)), 32'(memRead));
      checkValue("memWrite", 32'(modelState == EXEC_2 && cls == CLASS_STORE), 32'(memWrite));
      checkValue("iorD", 32'(modelState == EXEC_2 &&
                             cls inside {CLASS_LOAD, CLASS_STORE}), 32'(iorD));
      checkValue("byteEnable", 32'(expLanes), 32'(byteEnable));
      checkValue("memExt", 32'(expExt), 32'(memExt));
      checkValue("branchDelay", 32'(modelDelay), 32'(branchDelay));
      checkValue("pcSrc", 32'(modelDelay && modelState == FETCH), 32'(pcSrc));
      if (checkAlu) begin
        checkValue("aluControl", 32'(expAlu), 32'(aluControl));
        checkValue("aluSrcB", 32'(expSrcB), 32'(aluSrcB));
      end
    end
    if (retired < NumInstr) begin
      $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
               retired, NumInstr, cycles);
    end
    finishRun(retired < NumInstr);
  end

endmodule

//--- project.f
+incdir+verilog
verilog/controlPkg.sv
verilog/instrDecoder.sv
verilog/cycleSequencer.sv
verilog/datapathSelect.sv
verilog/memAccessControl.sv
verilog/branchResolver.sv
verilog/controlUnit.sv
verif/tbClock.sv
verif/tbControlUnit.sv

//--- run.sh
#!/bin/sh
# Builds and runs the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tbControlUnit -o simControlUnit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simControlUnit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1
